//--- include/gte_config.svh
`ifndef GTE_CONFIG_SVH
`define GTE_CONFIG_SVH

// Instruction field widths
`define GTE_OP_W   6   // Opcode field
`define GTE_PC_W   7   // Microprogram counter, 53 words used

// Control word widths
`define GTE_FLAG_W 19  // One bit per status flag
`define GTE_IDX_W  2   // Component index, 0 means none

`endif

//--- hw/gteOpPkg.sv
`default_nettype none

`include "gte_config.svh"

package gteOpPkg;

	// Kept instructions only
	typedef enum logic [`GTE_OP_W-1:0] {
		DPCS  = 6'h10,
		CDP   = 6'h14,
		CC    = 6'h1C,
		SQR   = 6'h28,
		AVSZ3 = 6'h2D,
		GPF   = 6'h3D,
		GPL   = 6'h3E
	} opcodeT;

	localparam logic [`GTE_PC_W-1:0] idlePc = 7'd52; // Single idle word, end of table

	// ROM start address per instruction
	function automatic logic [`GTE_PC_W-1:0] entryOf(opcodeT op);
		case (op)
			DPCS    : entryOf = 7'd0;
			CDP     : entryOf = 7'd8;
			CC      : entryOf = 7'd21;
			SQR     : entryOf = 7'd32;
			AVSZ3   : entryOf = 7'd37;
			GPF     : entryOf = 7'd42;
			GPL     : entryOf = 7'd47;
			default : entryOf = idlePc;  // Unknown op
		endcase
	endfunction

	// Number of microsteps per instruction
	function automatic int lengthOf(opcodeT op);
		case (op)
			DPCS    : lengthOf = 8;
			CDP     : lengthOf = 13;
			CC      : lengthOf = 11;
			SQR, AVSZ3, GPF, GPL : lengthOf = 5;
			default : lengthOf = 1;  // Idle step only
		endcase
	endfunction

endpackage

`default_nettype wire

//--- hw/gteUcodePkg.sv
`default_nettype none

`include "gte_config.svh"

package gteUcodePkg;

	// ------------------------------------------------------------------------
	// Write patterns, combined with a 2-bit component index
	// ------------------------------------------------------------------------
	typedef enum logic [3:0] {
		NONE = 4'd0, // No effect
		WMS  = 4'd1, // MACx + shadow IR
		WMF  = 4'd2, // MAC3 + IR3, shadow flush
		L0   = 4'd3, // No write, LM forced low
		WIC  = 4'd4, // MACx + IRx + colour push
		WI   = 4'd5, // MACx + IRx
		WMSC = 4'd6, // Shadow write with colour push
		DF   = 4'd7  // MAC0 + OTZ
	} writePatT;

	// One ROM word, 8 bits
	typedef struct packed {
		writePatT               pat;   // Write pattern
		logic [`GTE_IDX_W-1:0] idx;   // Component 1..3
		logic                   first; // Clears status
		logic                   last;  // Ends instruction
	} microWordT;

	// ------------------------------------------------------------------------
	// Flag mask bit positions, MSB first
	// ------------------------------------------------------------------------
	localparam int unsigned flagA1PPos = 18; // MAC1 overflow positive
	localparam int unsigned flagA2PPos = 17;
	localparam int unsigned flagA3PPos = 16;
	localparam int unsigned flagA1NPos = 15; // MAC1 overflow negative
	localparam int unsigned flagA2NPos = 14;
	localparam int unsigned flagA3NPos = 13;
	localparam int unsigned flagB1Pos  = 12; // IR1 saturated
	localparam int unsigned flagB2Pos  = 11;
	localparam int unsigned flagB3Pos  = 10;
	localparam int unsigned flagC1Pos  = 9;  // Colour R saturated
	localparam int unsigned flagC2Pos  = 8;
	localparam int unsigned flagC3Pos  = 7;
	localparam int unsigned flagDPos   = 6;  // OTZ saturated
	localparam int unsigned flagEPos   = 5;  // Divide overflow
	localparam int unsigned flagFPPos  = 4;  // MAC0 positive overflow
	localparam int unsigned flagFNPos  = 3;  // MAC0 negative overflow
	localparam int unsigned flagG1Pos  = 2;  // SX2 saturated
	localparam int unsigned flagG2Pos  = 1;  // SY2 saturated
	localparam int unsigned flagHPos   = 0;  // IR0 saturated

endpackage

`default_nettype wire

//--- hw/gteMicroSequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "gte_config.svh"

module gteMicroSequencer (
	input  wire logic                  clk,
	input  wire logic                  arstN,
	input  wire logic                  instrStart, // One-cycle strobe
	input  wire gteOpPkg::opcodeT      instrOp,
	input  wire logic                  instrLm,
	input  wire logic                  instrSf,
	input  wire logic [`GTE_PC_W-1:0] entryPc,    // From ROM lookup
	input  wire logic                  stepLast,   // Current word ends instruction
	output logic      [`GTE_PC_W-1:0] pc,
	output logic                       busy,
	output logic                       lmLatched,
	output logic                       sfLatched
);

	logic accept;

	assign accept = instrStart && !busy; // Starts while busy are dropped

	// ------------------------------------------------------------------------
	// Program counter and busy
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc        <= '0;
			busy      <= 1'b0;
			lmLatched <= 1'b0;
			sfLatched <= 1'b0;
		end else if (accept) begin
			pc        <= entryPc;     // Unknown op already maps to idle word
			busy      <= 1'b1;
			lmLatched <= instrLm;     // Held for whole instruction
			sfLatched <= instrSf;
		end else if (busy) begin
			pc <= pc + 7'd1;          // One word per cycle
			if (stepLast)
				busy <= 1'b0;         // Last word issued this edge
		end
	end

endmodule

`default_nettype wire

//--- hw/gteMicrocodeRom.sv
`timescale 1ns/1ps
`default_nettype none

`include "gte_config.svh"

module gteMicrocodeRom (
	input  wire gteOpPkg::opcodeT         instrOp,
	input  wire logic [`GTE_PC_W-1:0]    pc,
	output logic      [`GTE_PC_W-1:0]    entryPc,
	output gteUcodePkg::microWordT        word
);

	assign entryPc = gteOpPkg::entryOf(instrOp); // Unknown op maps to idle word

	// ------------------------------------------------------------------------
	// Microword table, fields are pattern, index, first, last
	// ------------------------------------------------------------------------
	always_comb begin
		case (pc)
			7'd0  : word = '{gteUcodePkg::NONE, 2'd0, 1'b1, 1'b0}; // DPCS 00
			7'd1  : word = '{gteUcodePkg::L0,   2'd1, 1'b0, 1'b0}; // DPCS 01
			7'd2  : word = '{gteUcodePkg::WIC,  2'd1, 1'b0, 1'b0}; // DPCS 02
			7'd3  : word = '{gteUcodePkg::L0,   2'd2, 1'b0, 1'b0}; // DPCS 03
			7'd4  : word = '{gteUcodePkg::WIC,  2'd2, 1'b0, 1'b0}; // DPCS 04
			7'd5  : word = '{gteUcodePkg::L0,   2'd3, 1'b0, 1'b0}; // DPCS 05
			7'd6  : word = '{gteUcodePkg::WIC,  2'd3, 1'b0, 1'b0}; // DPCS 06
			7'd7  : word = '{gteUcodePkg::NONE, 2'd0, 1'b0, 1'b1}; // DPCS 07

			7'd8  : word = '{gteUcodePkg::NONE, 2'd0, 1'b1, 1'b0}; // CDP 00
			7'd9  : word = '{gteUcodePkg::NONE, 2'd0, 1'b0, 1'b0}; // CDP 01
			7'd10 : word = '{gteUcodePkg::WMS,  2'd1, 1'b0, 1'b0}; // CDP 02
			7'd11 : word = '{gteUcodePkg::NONE, 2'd0, 1'b0, 1'b0}; // CDP 03
			7'd12 : word = '{gteUcodePkg::WMS,  2'd2, 1'b0, 1'b0}; // CDP 04
			7'd13 : word = '{gteUcodePkg::NONE, 2'd0, 1'b0, 1'b0}; // CDP 05
			7'd14 : word = '{gteUcodePkg::WMF,  2'd3, 1'b0, 1'b0}; // CDP 06, flush shadow
			7'd15 : word = '{gteUcodePkg::L0,   2'd1, 1'b0, 1'b0}; // CDP 07
			7'd16 : word = '{gteUcodePkg::WIC,  2'd1, 1'b0, 1'b0}; // CDP 08
			7'd17 : word = '{gteUcodePkg::L0,   2'd2, 1'b0, 1'b0}; // CDP 09
			7'd18 : word = '{gteUcodePkg::WIC,  2'd2, 1'b0, 1'b0}; // CDP 10
			7'd19 : word = '{gteUcodePkg::L0,   2'd3, 1'b0, 1'b0}; // CDP 11
			7'd20 : word = '{gteUcodePkg::WIC,  2'd3, 1'b0, 1'b1}; // CDP 12

			7'd21 : word = '{gteUcodePkg::NONE, 2'd0, 1'b1, 1'b0}; // CC 00
			7'd22 : word = '{gteUcodePkg::NONE, 2'd0, 1'b0, 1'b0}; // CC 01
			7'd23 : word = '{gteUcodePkg::WMS,  2'd1, 1'b0, 1'b0}; // CC 02
			7'd24 : word = '{gteUcodePkg::NONE, 2'd0, 1'b0, 1'b0}; // CC 03
			7'd25 : word = '{gteUcodePkg::WMS,  2'd2, 1'b0, 1'b0}; // CC 04
			7'd26 : word = '{gteUcodePkg::NONE, 2'd0, 1'b0, 1'b0}; // CC 05
			7'd27 : word = '{gteUcodePkg::WMF,  2'd3, 1'b0, 1'b0}; // CC 06
			7'd28 : word = '{gteUcodePkg::WIC,  2'd1, 1'b0, 1'b0}; // CC 07
			7'd29 : word = '{gteUcodePkg::WIC,  2'd2, 1'b0, 1'b0}; // CC 08
			7'd30 : word = '{gteUcodePkg::WIC,  2'd3, 1'b0, 1'b0}; // CC 09
			7'd31 : word = '{gteUcodePkg::NONE, 2'd0, 1'b0, 1'b1}; // CC 10

			7'd32 : word = '{gteUcodePkg::NONE, 2'd0, 1'b1, 1'b0}; // SQR 00
			7'd33 : word = '{gteUcodePkg::WI,   2'd1, 1'b0, 1'b0}; // SQR 01
			7'd34 : word = '{gteUcodePkg::WI,   2'd2, 1'b0, 1'b0}; // SQR 02
			7'd35 : word = '{gteUcodePkg::WI,   2'd3, 1'b0, 1'b0}; // SQR 03
			7'd36 : word = '{gteUcodePkg::NONE, 2'd0, 1'b0, 1'b1}; // SQR 04

			7'd37 : word = '{gteUcodePkg::NONE, 2'd0, 1'b1, 1'b0}; // AVSZ3 00
			7'd38 : word = '{gteUcodePkg::NONE, 2'd0, 1'b0, 1'b0}; // AVSZ3 01
			7'd39 : word = '{gteUcodePkg::NONE, 2'd0, 1'b0, 1'b0}; // AVSZ3 02
			7'd40 : word = '{gteUcodePkg::DF,   2'd0, 1'b0, 1'b0}; // AVSZ3 03, OTZ out
			7'd41 : word = '{gteUcodePkg::NONE, 2'd0, 1'b0, 1'b1}; // AVSZ3 04

			7'd42 : word = '{gteUcodePkg::WIC,  2'd1, 1'b1, 1'b0}; // GPF 00, IRx ready at once
			7'd43 : word = '{gteUcodePkg::WIC,  2'd2, 1'b0, 1'b0}; // GPF 01
			7'd44 : word = '{gteUcodePkg::WIC,  2'd3, 1'b0, 1'b0}; // GPF 02
			7'd45 : word = '{gteUcodePkg::NONE, 2'd0, 1'b0, 1'b0}; // GPF 03
			7'd46 : word = '{gteUcodePkg::NONE, 2'd0, 1'b0, 1'b1}; // GPF 04

			7'd47 : word = '{gteUcodePkg::NONE, 2'd0, 1'b1, 1'b0}; // GPL 00, MAC1 read delay
			7'd48 : word = '{gteUcodePkg::WIC,  2'd1, 1'b0, 1'b0}; // GPL 01
			7'd49 : word = '{gteUcodePkg::WIC,  2'd2, 1'b0, 1'b0}; // GPL 02
			7'd50 : word = '{gteUcodePkg::WIC,  2'd3, 1'b0, 1'b0}; // GPL 03
			7'd51 : word = '{gteUcodePkg::NONE, 2'd0, 1'b0, 1'b1}; // GPL 04

			7'd52 : word = '{gteUcodePkg::NONE, 2'd0, 1'b1, 1'b1}; // Idle, first and last
			default : word = '{gteUcodePkg::NONE, 2'd0, 1'b1, 1'b1}; // Off table, end at once
		endcase
	end

endmodule

`default_nettype wire

//--- hw/gteWriteDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "gte_config.svh"

module gteWriteDecode (
	input  wire logic                    clk,
	input  wire logic                    arstN,
	input  wire logic                    busy,
	input  wire gteUcodePkg::microWordT  word,
	input  wire logic                    lmLatched,
	input  wire logic                    sfLatched,
	output logic                         gtePshR,
	output logic                         gtePshG,
	output logic                         gtePshB,
	output logic [3:0]                   gteWrtMac,      // MAC0..MAC3
	output logic [3:0]                   gteWrtIR,       // IR0..IR3
	output logic                         gteWrtShadowIR, // Into shadow FIFO
	output logic                         gteCpyShadowIR, // Shadow to real IR
	output logic                         gteWrtOTZ,
	output logic [`GTE_FLAG_W-1:0]      gteFlagMask,
	output logic                         gteLM,
	output logic                         gteSF,
	output logic                         gteResetStatus,
	output logic                         gteLastMicroInstruction
);

	logic [3:0]              sel;        // One-hot component, bit 0 unused
	logic [`GTE_FLAG_W-1:0] abMask;     // Ax+/Ax-/Bx for index
	logic [`GTE_FLAG_W-1:0] cMask;      // Cx for index
	logic [3:0]              macNext;
	logic [3:0]              irNext;
	logic [2:0]              pushNext;   // {B,G,R}
	logic                    shadowNext;
	logic                    flushNext;
	logic                    otzNext;
	logic                    lmZero;     // L0 step
	logic [`GTE_FLAG_W-1:0] flagNext;

	// ------------------------------------------------------------------------
	// Index expansion
	// ------------------------------------------------------------------------
	always_comb begin
		sel    = 4'b0000;
		abMask = '0;
		cMask  = '0;
		case (word.idx)
			2'd1 : begin
				sel = 4'b0010;
				abMask[gteUcodePkg::flagA1PPos] = 1'b1;
				abMask[gteUcodePkg::flagA1NPos] = 1'b1;
				abMask[gteUcodePkg::flagB1Pos]  = 1'b1;
				cMask[gteUcodePkg::flagC1Pos]   = 1'b1;
			end
			2'd2 : begin
				sel = 4'b0100;
				abMask[gteUcodePkg::flagA2PPos] = 1'b1;
				abMask[gteUcodePkg::flagA2NPos] = 1'b1;
				abMask[gteUcodePkg::flagB2Pos]  = 1'b1;
				cMask[gteUcodePkg::flagC2Pos]   = 1'b1;
			end
			2'd3 : begin
				sel = 4'b1000;
				abMask[gteUcodePkg::flagA3PPos] = 1'b1;
				abMask[gteUcodePkg::flagA3NPos] = 1'b1;
				abMask[gteUcodePkg::flagB3Pos]  = 1'b1;
				cMask[gteUcodePkg::flagC3Pos]   = 1'b1;
			end
			default : ;                              // No component
		endcase
	end

	// ------------------------------------------------------------------------
	// Pattern expansion, all inactive when idle
	// ------------------------------------------------------------------------
	always_comb begin
		macNext    = 4'b0000;
		irNext     = 4'b0000;
		pushNext   = 3'b000;
		shadowNext = 1'b0;
		flushNext  = 1'b0;
		otzNext    = 1'b0;
		lmZero     = 1'b0;
		flagNext   = '0;
		if (busy) begin
			case (word.pat)
				gteUcodePkg::WMS : begin
					macNext    = sel;
					shadowNext = 1'b1;
					flagNext   = abMask;
				end
				gteUcodePkg::WMF : begin
					macNext   = sel;           // Index is 3 here
					irNext    = sel;
					flushNext = 1'b1;
					flagNext  = abMask;
				end
				gteUcodePkg::L0 : begin
					lmZero   = 1'b1;           // Flags only, unclamped low side
					flagNext = abMask;
				end
				gteUcodePkg::WIC : begin
					macNext  = sel;
					irNext   = sel;
					pushNext = sel[3:1];       // R/G/B by index
					flagNext = abMask | cMask;
				end
				gteUcodePkg::WI : begin
					macNext  = sel;
					irNext   = sel;
					flagNext = abMask;
				end
				gteUcodePkg::WMSC : begin
					macNext    = sel;
					shadowNext = 1'b1;
					pushNext   = sel[3:1];
					flagNext   = abMask | cMask;
				end
				gteUcodePkg::DF : begin
					macNext = 4'b0001;         // MAC0
					otzNext = 1'b1;
					flagNext[gteUcodePkg::flagDPos]  = 1'b1;
					flagNext[gteUcodePkg::flagFPPos] = 1'b1;
					flagNext[gteUcodePkg::flagFNPos] = 1'b1;
				end
				default : ;                    // NONE
			endcase
		end
	end

	// Output stage, one cycle after the ROM word
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			{gtePshB, gtePshG, gtePshR} <= 3'b000;
			gteWrtMac               <= 4'b0000;
			gteWrtIR                <= 4'b0000;
			gteWrtShadowIR          <= 1'b0;
			gteCpyShadowIR          <= 1'b0;
			gteWrtOTZ               <= 1'b0;
			gteFlagMask             <= '0;
			gteLM                   <= 1'b0;
			gteSF                   <= 1'b0;
			gteResetStatus          <= 1'b0;
			gteLastMicroInstruction <= 1'b0;
		end else begin
			{gtePshB, gtePshG, gtePshR} <= pushNext;
			gteWrtMac               <= macNext;
			gteWrtIR                <= irNext;
			gteWrtShadowIR          <= shadowNext;
			gteCpyShadowIR          <= flushNext;
			gteWrtOTZ               <= otzNext;
			gteFlagMask             <= flagNext;
			gteLM                   <= busy && lmLatched && !lmZero; // L0 forces 0
			gteSF                   <= busy && sfLatched;
			gteResetStatus          <= busy && word.first;
			gteLastMicroInstruction <= busy && word.last;
		end
	end

endmodule

`default_nettype wire

//--- hw/gteMicrocode.sv
`timescale 1ns/1ps
`default_nettype none

`include "gte_config.svh"

module gteMicrocode (
	input  wire logic                 clk,
	input  wire logic                 arstN,
	input  wire logic                 instrStart,
	input  wire gteOpPkg::opcodeT     instrOp,
	input  wire logic                 instrLm,
	input  wire logic                 instrSf,
	output logic                      busy,
	output logic                      gtePshR,
	output logic                      gtePshG,
	output logic                      gtePshB,
	output logic [3:0]                gteWrtMac,
	output logic [3:0]                gteWrtIR,
	output logic                      gteWrtShadowIR,
	output logic                      gteCpyShadowIR,
	output logic                      gteWrtOTZ,
	output logic [`GTE_FLAG_W-1:0]   gteFlagMask,
	output logic                      gteLM,
	output logic                      gteSF,
	output logic                      gteResetStatus,
	output logic                      gteLastMicroInstruction
);

	logic [`GTE_PC_W-1:0]   pc;        // Current ROM address
	logic [`GTE_PC_W-1:0]   entryPc;   // Start address of incoming op
	gteUcodePkg::microWordT word;      // ROM output, same cycle as pc
	logic                   lmLatched;
	logic                   sfLatched;

	// ------------------------------------------------------------------------
	// Sequencer, ROM, decoder
	// ------------------------------------------------------------------------
	gteMicroSequencer uSeq (
		.clk        (clk),
		.arstN      (arstN),
		.instrStart (instrStart),
		.instrOp    (instrOp),
		.instrLm    (instrLm),
		.instrSf    (instrSf),
		.entryPc    (entryPc),
		.stepLast   (word.last),
		.pc         (pc),
		.busy       (busy),
		.lmLatched  (lmLatched),
		.sfLatched  (sfLatched)
	);

	gteMicrocodeRom uRom (
		.instrOp (instrOp),
		.pc      (pc),
		.entryPc (entryPc),
		.word    (word)
	);

	gteWriteDecode uDec (
		.clk                     (clk),
		.arstN                   (arstN),
		.busy                    (busy),
		.word                    (word),
		.lmLatched               (lmLatched),
		.sfLatched               (sfLatched),
		.gtePshR                 (gtePshR),
		.gtePshG                 (gtePshG),
		.gtePshB                 (gtePshB),
		.gteWrtMac               (gteWrtMac),
		.gteWrtIR                (gteWrtIR),
		.gteWrtShadowIR          (gteWrtShadowIR),
		.gteCpyShadowIR          (gteCpyShadowIR),
		.gteWrtOTZ               (gteWrtOTZ),
		.gteFlagMask             (gteFlagMask),
		.gteLM                   (gteLM),
		.gteSF                   (gteSF),
		.gteResetStatus          (gteResetStatus),
		.gteLastMicroInstruction (gteLastMicroInstruction)
	);

endmodule

`default_nettype wire

//--- sim/gteMicrocode_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "gte_config.svh"

module gteMicrocodeSva (
	input wire logic                   clk,
	input wire logic                   arstN,
	input wire logic                   busy,
	input wire logic                   gtePshR,
	input wire logic                   gtePshG,
	input wire logic                   gtePshB,
	input wire logic [3:0]             gteWrtMac,
	input wire logic [3:0]             gteWrtIR,
	input wire logic                   gteWrtShadowIR,
	input wire logic                   gteCpyShadowIR,
	input wire logic                   gteWrtOTZ,
	input wire logic [`GTE_FLAG_W-1:0] gteFlagMask,
	input wire logic                   gteLM,
	input wire logic                   gteSF,
	input wire logic                   gteResetStatus,
	input wire logic                   gteLastMicroInstruction
);

	// ------------------------------------------------------------------------
	// Output sanity
	// ------------------------------------------------------------------------
	pushOneHot : assert property (@(posedge clk) disable iff (!arstN)
		$onehot0({gtePshR, gtePshG, gtePshB}))
		else $error("colour push not one-hot");

	shadowOneHot : assert property (@(posedge clk) disable iff (!arstN)
		$onehot0({gteWrtShadowIR, gteCpyShadowIR}))
		else $error("shadow write and copy together");

	lastEndsBusy : assert property (@(posedge clk) disable iff (!arstN)
		gteLastMicroInstruction |-> !busy)
		else $error("busy still high with last step");

	// Decoder registers idle controls one cycle after busy low
	idleQuiet : assert property (@(posedge clk) disable iff (!arstN)
		!busy |=> ({gtePshR, gtePshG, gtePshB, gteWrtMac, gteWrtIR, gteWrtShadowIR,
			gteCpyShadowIR, gteWrtOTZ, gteFlagMask, gteLM, gteSF, gteResetStatus,
			gteLastMicroInstruction} == '0))
		else $error("control active after idle cycle");

endmodule

`default_nettype wire

//--- sim/gteMicrocodeChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "gte_config.svh"

module gteMicrocodeChecker (
	input  wire logic                   clk,
	input  wire logic                   arstN,
	input  wire logic                   instrStart,
	input  wire gteOpPkg::opcodeT       instrOp,
	input  wire logic                   instrLm,
	input  wire logic                   instrSf,
	input  wire logic                   busy,
	input  wire logic                   gtePshR,
	input  wire logic                   gtePshG,
	input  wire logic                   gtePshB,
	input  wire logic [3:0]             gteWrtMac,
	input  wire logic [3:0]             gteWrtIR,
	input  wire logic                   gteWrtShadowIR,
	input  wire logic                   gteCpyShadowIR,
	input  wire logic                   gteWrtOTZ,
	input  wire logic [`GTE_FLAG_W-1:0] gteFlagMask,
	input  wire logic                   gteLM,
	input  wire logic                   gteSF,
	input  wire logic                   gteResetStatus,
	input  wire logic                   gteLastMicroInstruction,
	output int                          errorCount,
	output int                          checkCount
);

	typedef struct packed {
		logic [2:0]             push;   // {B,G,R}
		logic [3:0]             mac;
		logic [3:0]             ir;
		logic                   shadow;
		logic                   cpy;
		logic                   otz;
		logic [`GTE_FLAG_W-1:0] flag;
		logic                   lm;
		logic                   sf;
		logic                   rst;
		logic                   last;
	} ctrlT;

	// ------------------------------------------------------------------------
	// Step table
	// ------------------------------------------------------------------------
	function automatic logic [5:0] mk(gteUcodePkg::writePatT p, int i);
		mk = {p, i[1:0]};
	endfunction

	function automatic logic [5:0] stepOf(gteOpPkg::opcodeT op, int s);
		stepOf = mk(gteUcodePkg::NONE, 0); // Unlisted steps do nothing
		case (op)
			gteOpPkg::DPCS : case (s)
				1 : stepOf = mk(gteUcodePkg::L0, 1);
				2 : stepOf = mk(gteUcodePkg::WIC, 1);
				3 : stepOf = mk(gteUcodePkg::L0, 2);
				4 : stepOf = mk(gteUcodePkg::WIC, 2);
				5 : stepOf = mk(gteUcodePkg::L0, 3);
				6 : stepOf = mk(gteUcodePkg::WIC, 3);
				default : ;
			endcase
			gteOpPkg::CDP, gteOpPkg::CC : case (s)
				2 : stepOf = mk(gteUcodePkg::WMS, 1);
				4 : stepOf = mk(gteUcodePkg::WMS, 2);
				6 : stepOf = mk(gteUcodePkg::WMF, 3);
				default : begin
					if (op == gteOpPkg::CDP && s >= 7) // L0/WIC pairs
						stepOf = mk((s % 2) ? gteUcodePkg::L0 : gteUcodePkg::WIC,
							(s - 5) / 2);
					else if (op == gteOpPkg::CC && s >= 7 && s <= 9)
						stepOf = mk(gteUcodePkg::WIC, s - 6);
				end
			endcase
			gteOpPkg::SQR   : if (s >= 1 && s <= 3) stepOf = mk(gteUcodePkg::WI, s);
			gteOpPkg::AVSZ3 : if (s == 3) stepOf = mk(gteUcodePkg::DF, 0);
			gteOpPkg::GPF   : if (s <= 2) stepOf = mk(gteUcodePkg::WIC, s + 1);
			gteOpPkg::GPL   : if (s >= 1 && s <= 3) stepOf = mk(gteUcodePkg::WIC, s);
			default : ;
		endcase
	endfunction

	// ------------------------------------------------------------------------
	// Reference controls for one step
	// ------------------------------------------------------------------------
	function automatic ctrlT refCtrl(logic valid, gteOpPkg::opcodeT op, int s,
		logic lm, logic sf);
		ctrlT c;
		logic [5:0] e;
		gteUcodePkg::writePatT pat;
		int i;
		logic [3:0] oneHot;
		logic [`GTE_FLAG_W-1:0] ab;
		logic [`GTE_FLAG_W-1:0] cc;
		c = '0;
		if (valid) begin
			e      = stepOf(op, s);
			pat    = gteUcodePkg::writePatT'(e[5:2]);
			i      = int'(e[1:0]);
			oneHot = (i == 0) ? 4'b0000 : 4'b0001 << i;
			ab     = '0;
			cc     = '0;
			if (i != 0) begin
				ab[gteUcodePkg::flagA1PPos - (i - 1)] = 1'b1; // Ax+ run downward by index
				ab[gteUcodePkg::flagA1NPos - (i - 1)] = 1'b1;
				ab[gteUcodePkg::flagB1Pos - (i - 1)]  = 1'b1;
				cc[gteUcodePkg::flagC1Pos - (i - 1)]  = 1'b1;
			end
			case (pat)
				gteUcodePkg::WMS  : begin
					c.mac    = oneHot;
					c.shadow = 1'b1;
					c.flag   = ab;
				end
				gteUcodePkg::WMF  : begin
					c.mac  = oneHot;
					c.ir   = oneHot;
					c.cpy  = 1'b1;
					c.flag = ab;
				end
				gteUcodePkg::L0   : c.flag = ab;
				gteUcodePkg::WIC  : begin
					c.mac  = oneHot;
					c.ir   = oneHot;
					c.push = oneHot[3:1];
					c.flag = ab | cc;
				end
				gteUcodePkg::WI   : begin
					c.mac  = oneHot;
					c.ir   = oneHot;
					c.flag = ab;
				end
				gteUcodePkg::WMSC : begin
					c.mac    = oneHot;
					c.shadow = 1'b1;
					c.push   = oneHot[3:1];
					c.flag   = ab | cc;
				end
				gteUcodePkg::DF   : begin
					c.mac = 4'b0001; // MAC0
					c.otz = 1'b1;
					c.flag[gteUcodePkg::flagDPos]  = 1'b1;
					c.flag[gteUcodePkg::flagFPPos] = 1'b1;
					c.flag[gteUcodePkg::flagFNPos] = 1'b1;
				end
				default : ;
			endcase
			c.lm   = lm && (pat != gteUcodePkg::L0);
			c.sf   = sf;
			c.rst  = (s == 0);
			c.last = (s == gteOpPkg::lengthOf(op) - 1);
		end
		refCtrl = c;
	endfunction

	// Instruction model counted at the same edges as the DUT
	logic             mBusy;
	gteOpPkg::opcodeT mOp;
	int               mStep;
	logic             mLm;
	logic             mSf;
	logic             oValid;
	gteOpPkg::opcodeT oOp;
	int               oStep;
	logic             oLm;
	logic             oSf;
	ctrlT             expCtrl;
	ctrlT             actCtrl;

	always @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			mBusy  <= 1'b0;
			mOp    <= gteOpPkg::DPCS;
			mStep  <= 0;
			mLm    <= 1'b0;
			mSf    <= 1'b0;
			oValid <= 1'b0;
			oOp    <= gteOpPkg::DPCS;
			oStep  <= 0;
			oLm    <= 1'b0;
			oSf    <= 1'b0;
		end else begin
			oValid <= mBusy; // Decoder output one cycle behind
			oOp    <= mOp;
			oStep  <= mStep;
			oLm    <= mLm;
			oSf    <= mSf;
			if (!mBusy && instrStart) begin
				mBusy <= 1'b1;
				mOp   <= instrOp;
				mStep <= 0;
				mLm   <= instrLm;
				mSf   <= instrSf;
			end else if (mBusy) begin
				mStep <= mStep + 1;
				if (mStep == gteOpPkg::lengthOf(mOp) - 1)
					mBusy <= 1'b0;
			end
		end
	end

	initial begin
		errorCount = 0;
		checkCount = 0;
	end

	// Compare mid cycle when all outputs are settled
	always @(negedge clk) begin
		expCtrl        = refCtrl(oValid, oOp, oStep, oLm, oSf);
		actCtrl        = '0;
		actCtrl.push   = {gtePshB, gtePshG, gtePshR};
		actCtrl.mac    = gteWrtMac;
		actCtrl.ir     = gteWrtIR;
		actCtrl.shadow = gteWrtShadowIR;
		actCtrl.cpy    = gteCpyShadowIR;
		actCtrl.otz    = gteWrtOTZ;
		actCtrl.flag   = gteFlagMask;
		actCtrl.lm     = gteLM;
		actCtrl.sf     = gteSF;
		actCtrl.rst    = gteResetStatus;
		actCtrl.last   = gteLastMicroInstruction;
		checkCount++;
		if (actCtrl !== expCtrl) begin
			errorCount++;
			$display("ERROR @%0t: op %h step %0d controls expected %h got %h",
				$time, oOp, oStep, expCtrl, actCtrl);
		end
		if (busy !== mBusy) begin
			errorCount++;
			$display("ERROR @%0t: busy expected %b got %b", $time, mBusy, busy);
		end
	end

endmodule

`default_nettype wire

//--- sim/tbGteMicrocode.sv
`timescale 1ns/1ps
`default_nettype none

`include "gte_config.svh"

module tbGteMicrocode;

	localparam int numInstr    = 200;
	localparam int watchdogNs  = 300 * 16 * 8 + 16 * 8; // Instructions x cycles x period plus reset

	logic                   clk;
	logic                   arstN;
	logic                   instrStart;
	gteOpPkg::opcodeT       instrOp;
	logic                   instrLm;
	logic                   instrSf;
	logic                   busy;
	logic                   gtePshR;
	logic                   gtePshG;
	logic                   gtePshB;
	logic [3:0]             gteWrtMac;
	logic [3:0]             gteWrtIR;
	logic                   gteWrtShadowIR;
	logic                   gteCpyShadowIR;
	logic                   gteWrtOTZ;
	logic [`GTE_FLAG_W-1:0] gteFlagMask;
	logic                   gteLM;
	logic                   gteSF;
	logic                   gteResetStatus;
	logic                   gteLastMicroInstruction;
	int                     errorCount;
	int                     checkCount;
	integer                 seed;

	always #4 clk = ~clk; // 8 ns period

	gteMicrocode dut (
		.clk(clk), .arstN(arstN), .instrStart(instrStart), .instrOp(instrOp),
		.instrLm(instrLm), .instrSf(instrSf), .busy(busy),
		.gtePshR(gtePshR), .gtePshG(gtePshG), .gtePshB(gtePshB),
		.gteWrtMac(gteWrtMac), .gteWrtIR(gteWrtIR), .gteWrtShadowIR(gteWrtShadowIR),
		.gteCpyShadowIR(gteCpyShadowIR), .gteWrtOTZ(gteWrtOTZ), .gteFlagMask(gteFlagMask),
		.gteLM(gteLM), .gteSF(gteSF), .gteResetStatus(gteResetStatus),
		.gteLastMicroInstruction(gteLastMicroInstruction)
	);

	gteMicrocodeChecker uChk (
		.clk(clk), .arstN(arstN), .instrStart(instrStart), .instrOp(instrOp),
		.instrLm(instrLm), .instrSf(instrSf), .busy(busy),
		.gtePshR(gtePshR), .gtePshG(gtePshG), .gtePshB(gtePshB),
		.gteWrtMac(gteWrtMac), .gteWrtIR(gteWrtIR), .gteWrtShadowIR(gteWrtShadowIR),
		.gteCpyShadowIR(gteCpyShadowIR), .gteWrtOTZ(gteWrtOTZ), .gteFlagMask(gteFlagMask),
		.gteLM(gteLM), .gteSF(gteSF), .gteResetStatus(gteResetStatus),
		.gteLastMicroInstruction(gteLastMicroInstruction),
		.errorCount(errorCount), .checkCount(checkCount)
	);

	bind gteMicrocode gteMicrocodeSva uSva (
		.clk(clk), .arstN(arstN), .busy(busy),
		.gtePshR(gtePshR), .gtePshG(gtePshG), .gtePshB(gtePshB),
		.gteWrtMac(gteWrtMac), .gteWrtIR(gteWrtIR), .gteWrtShadowIR(gteWrtShadowIR),
		.gteCpyShadowIR(gteCpyShadowIR), .gteWrtOTZ(gteWrtOTZ), .gteFlagMask(gteFlagMask),
		.gteLM(gteLM), .gteSF(gteSF), .gteResetStatus(gteResetStatus),
		.gteLastMicroInstruction(gteLastMicroInstruction)
	);

	// Mostly kept opcodes and a quarter random
	task automatic pickOp(output gteOpPkg::opcodeT op);
		int r;
		r = $random(seed);
		case (r & 15)
			0, 1    : op = gteOpPkg::DPCS;
			2, 3    : op = gteOpPkg::CDP;
			4, 5    : op = gteOpPkg::CC;
			6       : op = gteOpPkg::SQR;
			7       : op = gteOpPkg::AVSZ3;
			8, 9    : op = gteOpPkg::GPF;
			10, 11  : op = gteOpPkg::GPL;
			default : op = gteOpPkg::opcodeT'(r[9:4]); // Usually unknown
		endcase
	endtask

	task automatic issueInstr();
		gteOpPkg::opcodeT op;
		int r;
		pickOp(op);
		@(posedge clk);
		instrStart <= 1'b1;
		instrOp    <= op;
		r = $random(seed);
		instrLm    <= r[0];
		instrSf    <= r[1];
		@(posedge clk);                     // Start sampled here
		instrStart <= 1'b0;
		@(negedge clk);
		while (busy) begin
			pickOp(op);
			r = $random(seed);
			@(posedge clk);
			instrStart <= (r[4:2] == 3'd0); // Extra start ignored while busy
			instrOp    <= op;
			instrLm    <= r[0];
			instrSf    <= r[1];
			@(negedge clk);
		end
	endtask

	initial begin
		seed       = 32'hb6cfdbc6;
		clk        = 1'b0;
		arstN      <= 1'b0;
		instrStart <= 1'b0;
		instrOp    <= gteOpPkg::DPCS;
		instrLm    <= 1'b0;
		instrSf    <= 1'b0;
		repeat (16) @(posedge clk);
		arstN <= 1'b1;
		repeat (2) @(posedge clk);
		for (int i = 0; i < numInstr; i++)
			issueInstr();
		@(posedge clk);
		instrStart <= 1'b0;
		repeat (20) @(posedge clk); // Drain any late accepted start
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// Watchdog
	initial begin
		#(watchdogNs);
		$display("Timeout: the run did not finish within %0d ns", watchdogNs);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
hw/gteOpPkg.sv
hw/gteUcodePkg.sv
hw/gteMicroSequencer.sv
hw/gteMicrocodeRom.sv
hw/gteWriteDecode.sv
hw/gteMicrocode.sv
sim/gteMicrocode_sva.sv
sim/gteMicrocodeChecker.sv
sim/tbGteMicrocode.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbGteMicrocode
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASSMSG   ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -F '$(PASSMSG)' > /dev/null

clean:
	rm -rf $(OBJDIR)
